// File: Makefile
SRCS := $(filter-out +%,$(shell cat tb.f))

obj_dir/Vtb_decode: tb.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_decode -f tb.f -o Vtb_decode

run: obj_dir/Vtb_decode
	./obj_dir/Vtb_decode | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: decode_pkg.sv
// Decode stage shared types
`default_nettype none

package decode_pkg;

    localparam int exc_w = 7; // one-hot exception vector width

    // one-hot exception codes
    localparam logic [exc_w-1:0] EXC_INE = 7'b000_0001; // illegal instruction
    localparam logic [exc_w-1:0] EXC_SYS = 7'b000_0010; // syscall
    localparam logic [exc_w-1:0] EXC_BRK = 7'b000_0100; // break
    localparam logic [exc_w-1:0] EXC_IPE = 7'b000_1000; // privilege error

    localparam logic [31:0] INST_NOP = 32'h0280_0000; // addi.w r0, r0, 0

    typedef enum logic [3:0] {
        op_none, op_add, op_sub, op_addi, op_lu12i, op_ld, op_st, op_beq,
        op_bne, op_b, op_bl, op_jirl, op_syscall, op_break, op_ertn, op_invalid
    } op_e;

    // branch class, also the low two bits of a predictor record
    typedef enum logic [1:0] {
        cat_plain, cat_cond, cat_direct, cat_indirect
    } category_e;

    typedef struct packed {
        logic             valid;
        logic [31:0]      inst0;
        logic [31:0]      inst1;
        logic [31:0]      pc;
        logic [31:0]      pc_next;
        logic [exc_w-1:0] exc;
        logic [31:0]      badv;
        logic             first_inst_jmp; // inst0 predicted taken
        logic             unknown0;
        logic             unknown1;
        logic [31:0]      pred_record0; // {target[31:2], category}
        logic [31:0]      pred_record1;
    } fetch_pair_t;

    typedef struct packed {
        logic [31:0]      inst;
        logic [31:0]      pc;
        logic [31:0]      pc_next;
        logic [exc_w-1:0] exc;
        logic [31:0]      badv;
        logic             unknown;
    } buf_entry_t; // 136 bits

    typedef struct packed {
        logic             valid;
        op_e              op;
        logic [4:0]       rd;
        logic [4:0]       rj;
        logic [4:0]       rk;
        logic [31:0]      imm;
        logic [31:0]      pc;
        logic [31:0]      pc_next;
        logic [exc_w-1:0] exc;
        logic [31:0]      badv;
        logic             unknown;
    } uop_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] jmpdist0;
        logic [31:0] jmpdist1;
        category_e   category0;
        category_e   category1;
    } predict_fb_t;

endpackage

`default_nettype wire

// File: decode_top.sv
// Decode stage top level
`timescale 1ns/1ps
`default_nettype none

module decode_top import decode_pkg::*; #(
    parameter int BANK_DEPTH = 8
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              flush,
    input  wire  [1:0]       plv,
    input  wire  [1:0]       read_en,
    input  wire fetch_pair_t fetch,
    output logic             full,
    output uop_t             uop0,
    output uop_t             uop1,
    output redirect_t        redirect,
    output predict_fb_t      feedback
);
    id_stage #(.BANK_DEPTH(BANK_DEPTH)) u_id (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .plv      (plv),
        .read_en  (read_en),
        .fetch    (fetch),
        .full     (full),
        .uop0     (uop0),
        .uop1     (uop1),
        .redirect (redirect),
        .feedback (feedback)
    );

endmodule

`default_nettype wire

// File: fetch_buffer.sv
// Two-bank interleaved fetch buffer
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import decode_pkg::*; #(
    parameter int BANK_DEPTH = 8
) (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             flush,
    input  wire             push0,   // in0 holds an instruction
    input  wire             push1,   // in1 holds one too
    input  wire buf_entry_t in0,
    input  wire buf_entry_t in1,
    input  wire  [1:0]      read_en,
    output logic            full,
    output buf_entry_t      head0,
    output buf_entry_t      head1,
    output logic            head0_valid,
    output logic            head1_valid
);
    localparam int ptr_w = $clog2(BANK_DEPTH);
    localparam logic [ptr_w-1:0] cnt_full  = ptr_w'(BANK_DEPTH - 1);
    localparam logic [ptr_w-1:0] cnt_early = ptr_w'(BANK_DEPTH - 3);

    buf_entry_t       bank0 [BANK_DEPTH];
    buf_entry_t       bank1 [BANK_DEPTH];
    logic [ptr_w-1:0] rd_ptr0, rd_ptr1;
    logic [ptr_w-1:0] wr_ptr0, wr_ptr1;
    logic [ptr_w-1:0] cnt0, cnt1;
    logic             push_sel; // bank that receives in0
    logic             pop_sel;  // bank holding the oldest entry
    logic             empty0, empty1;
    logic             really_full;
    logic             wr_en0, wr_en1;
    logic             pop_ok0, pop_ok1;

    assign cnt0   = wr_ptr0 - rd_ptr0;
    assign cnt1   = wr_ptr1 - rd_ptr1;
    assign empty0 = (cnt0 == '0);
    assign empty1 = (cnt1 == '0);

    // one slot per bank always stays unused
    assign really_full = (cnt0 == cnt_full) || (cnt1 == cnt_full);
    assign full        = (cnt0 >= cnt_early) || (cnt1 >= cnt_early); // room for one more pair

    assign wr_en0 = !really_full && ((push0 && push1) || (push0 && !push_sel));
    assign wr_en1 = !really_full && ((push0 && push1) || (push0 && push_sel));

    assign pop_ok0 = !empty0 && (read_en[1] || (read_en[0] && !pop_sel));
    assign pop_ok1 = !empty1 && (read_en[1] || (read_en[0] && pop_sel));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr0  <= '0;
            rd_ptr1  <= '0;
            wr_ptr0  <= '0;
            wr_ptr1  <= '0;
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else if (flush) begin
            rd_ptr0  <= '0;
            rd_ptr1  <= '0;
            wr_ptr0  <= '0;
            wr_ptr1  <= '0;
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else begin
            if (pop_ok0) rd_ptr0 <= rd_ptr0 + 1'b1;
            if (pop_ok1) rd_ptr1 <= rd_ptr1 + 1'b1;
            if (wr_en0)  wr_ptr0 <= wr_ptr0 + 1'b1;
            if (wr_en1)  wr_ptr1 <= wr_ptr1 + 1'b1;
            if (push0 && !push1 && !really_full) push_sel <= ~push_sel; // odd arrival
            if (pop_ok0 ^ pop_ok1) pop_sel <= ~pop_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en0) bank0[wr_ptr0] <= push_sel ? in1 : in0;
        if (wr_en1) bank1[wr_ptr1] <= push_sel ? in0 : in1;
    end

    assign head0       = pop_sel ? bank1[rd_ptr1] : bank0[rd_ptr0];
    assign head1       = pop_sel ? bank0[rd_ptr0] : bank1[rd_ptr1];
    assign head0_valid = pop_sel ? !empty1 : !empty0;
    assign head1_valid = head0_valid && (pop_sel ? !empty0 : !empty1);

    // downstream never pops slot 1 alone
    a_read_en_legal: assert property (@(posedge clk) disable iff (!arst_n)
        read_en != 2'b10);

    // fetch honours the early full
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push0 |-> !really_full);

    // interleaving keeps the banks within one entry of each other
    a_banks_balanced: assert property (@(posedge clk) disable iff (!arst_n)
        (cnt0 == cnt1) || (cnt0 == cnt1 + 1'b1) || (cnt1 == cnt0 + 1'b1));

endmodule

`default_nettype wire

// File: id_stage.sv
// Dual-issue instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage import decode_pkg::*; #(
    parameter int BANK_DEPTH = 8
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              flush,
    input  wire  [1:0]       plv,
    input  wire  [1:0]       read_en,
    input  wire fetch_pair_t fetch,
    output logic             full,
    output uop_t             uop0,
    output uop_t             uop1,
    output redirect_t        redirect,
    output predict_fb_t      feedback
);
    category_e   cat0, cat1;
    logic [31:0] offset0, offset1;
    logic [31:0] pc0, pc1;
    logic [31:0] target0, target1;
    logic        has_exc;
    logic        slot0_ok, slot1_ok;
    logic        taken0, taken1;
    logic [31:0] static_next0, static_next1;
    logic [31:0] pred_next0, pred_next1;
    logic        unk0, unk1;
    logic        hit0, hit1;
    logic        keep0, keep1;
    logic [31:0] fixed_next;
    buf_entry_t  entry0, entry1;
    buf_entry_t  in0, in1;
    buf_entry_t  head0, head1;
    logic        head0_valid, head1_valid;

    pre_decoder u_pre0 (.inst(fetch.inst0), .category(cat0), .pc_offset(offset0));
    pre_decoder u_pre1 (.inst(fetch.inst1), .category(cat1), .pc_offset(offset1));

    assign pc0     = fetch.pc;
    assign pc1     = fetch.pc[2] ? fetch.pc : fetch.pc + 32'd4; // odd pc, inst1 sits at pc
    assign target0 = pc0 + offset0;
    assign target1 = pc1 + offset1;

    // NOPs only travel when they carry a fetch fault
    assign has_exc  = (fetch.exc != '0);
    assign slot0_ok = fetch.valid && !fetch.pc[2] && (fetch.inst0 != INST_NOP || has_exc);
    assign slot1_ok = fetch.valid && !fetch.first_inst_jmp && (fetch.inst1 != INST_NOP || has_exc);

    // backward conditional branches guessed taken
    assign taken0 = (cat0 == cat_direct) || (cat0 == cat_cond && offset0[31]);
    assign taken1 = (cat1 == cat_direct) || (cat1 == cat_cond && offset1[31]);
    assign static_next0 = taken0 ? target0 : pc0 + 32'd4;
    assign static_next1 = taken1 ? target1 : pc1 + 32'd4;

    assign pred_next0 = fetch.first_inst_jmp ? fetch.pc_next : pc0 + 32'd4;
    assign pred_next1 = fetch.pc_next;

    assign unk0 = fetch.unknown0 || ({target0[31:2], cat0} != fetch.pred_record0);
    assign unk1 = fetch.unknown1 || ({target1[31:2], cat1} != fetch.pred_record1);

    assign hit0 = slot0_ok && unk0 && (pred_next0 != static_next0);
    assign hit1 = slot1_ok && unk1 && (pred_next1 != static_next1);

    always_comb begin
        redirect.valid     = hit0 || hit1;
        redirect.target    = hit0 ? static_next0 : static_next1;
        feedback.valid     = fetch.valid;
        feedback.pc        = fetch.pc;
        feedback.jmpdist0  = target0;
        feedback.jmpdist1  = target1;
        feedback.category0 = cat0;
        feedback.category1 = cat1;
    end

    assign keep0      = slot0_ok;
    assign keep1      = slot1_ok && !hit0; // fetch restarts behind slot 0
    assign fixed_next = redirect.valid ? redirect.target : fetch.pc_next;

    always_comb begin
        entry0.inst    = fetch.inst0;
        entry0.pc      = pc0;
        entry0.pc_next = hit0 ? static_next0 : pred_next0;
        entry0.exc     = fetch.exc;
        entry0.badv    = fetch.badv;
        entry0.unknown = unk0;
        entry1.inst    = fetch.inst1;
        entry1.pc      = pc1;
        entry1.pc_next = fixed_next;
        entry1.exc     = fetch.exc;
        entry1.badv    = fetch.badv;
        entry1.unknown = unk1;
    end

    // compact so that in0 is always the older one
    assign in0 = keep0 ? entry0 : entry1;
    assign in1 = entry1;

    fetch_buffer #(.BANK_DEPTH(BANK_DEPTH)) u_buf (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .push0       (keep0 || keep1),
        .push1       (keep0 && keep1),
        .in0         (in0),
        .in1         (in1),
        .read_en     (read_en),
        .full        (full),
        .head0       (head0),
        .head1       (head1),
        .head0_valid (head0_valid),
        .head1_valid (head1_valid)
    );

    inst_decoder u_dec0 (.entry(head0), .entry_valid(head0_valid), .plv(plv), .uop(uop0));
    inst_decoder u_dec1 (.entry(head1), .entry_valid(head1_valid), .plv(plv), .uop(uop1));

endmodule

`default_nettype wire

// File: inst_decoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  wire buf_entry_t entry,
    input  wire             entry_valid,
    input  wire  [1:0]      plv,
    output uop_t            uop
);
    logic [31:0]      inst;
    op_e              op;
    logic [31:0]      imm;
    logic [exc_w-1:0] dec_exc;

    assign inst = entry.inst;

    always_comb begin
        op  = op_invalid;
        imm = 32'd0;
        if (!entry_valid) begin
            op = op_none; // nothing behind this slot
        end else if (inst[31:15] == 17'h00020) begin
            op = op_add;
        end else if (inst[31:15] == 17'h00022) begin
            op = op_sub;
        end else if (inst[31:22] == 10'h00a) begin
            op  = op_addi;
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:25] == 7'b0001010) begin
            op  = op_lu12i;
            imm = {inst[24:5], 12'd0};
        end else if (inst[31:22] == 10'h0a2) begin
            op  = op_ld;
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:22] == 10'h0a6) begin
            op  = op_st;
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:26] == 6'b010110 || inst[31:26] == 6'b010111) begin
            op  = inst[26] ? op_bne : op_beq;
            imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == 6'b010100 || inst[31:26] == 6'b010101) begin
            op  = inst[26] ? op_bl : op_b;
            imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else if (inst[31:26] == 6'b010011) begin
            op  = op_jirl;
            imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:15] == 17'h00056) begin
            op  = op_syscall;
            imm = {17'd0, inst[14:0]}; // code field
        end else if (inst[31:15] == 17'h00054) begin
            op  = op_break;
            imm = {17'd0, inst[14:0]};
        end else if (inst == 32'h0648_3800) begin
            op = op_ertn;
        end
    end

    always_comb begin
        case (op)
            op_invalid: dec_exc = EXC_INE;
            op_syscall: dec_exc = EXC_SYS;
            op_break:   dec_exc = EXC_BRK;
            op_ertn:    dec_exc = (plv != 2'd0) ? EXC_IPE : '0; // kernel only
            default:    dec_exc = '0;
        endcase
    end

    always_comb begin
        uop         = '0;
        uop.valid   = entry_valid;
        uop.op      = op;
        uop.imm     = imm;
        uop.pc      = entry.pc;
        uop.pc_next = entry.pc_next;
        uop.badv    = entry.badv;
        uop.unknown = entry.unknown;
        uop.exc     = (entry.exc != '0) ? entry.exc : dec_exc; // fetch fault wins
        case (op)
            op_add, op_sub: begin
                uop.rd = inst[4:0];
                uop.rj = inst[9:5];
                uop.rk = inst[14:10];
            end
            op_addi, op_ld, op_st, op_beq, op_bne, op_jirl: begin
                uop.rd = inst[4:0]; // st and branches read rd
                uop.rj = inst[9:5];
            end
            op_lu12i: uop.rd = inst[4:0];
            op_bl:    uop.rd = 5'd1; // link register
            default:  ;
        endcase
    end

endmodule

`default_nettype wire

// File: pre_decoder.sv
// Branch predecoder
`timescale 1ns/1ps
`default_nettype none

module pre_decoder import decode_pkg::*; (
    input  wire  [31:0] inst,
    output category_e   category,
    output logic [31:0] pc_offset
);
    logic [31:0] offs16;
    logic [31:0] offs26;

    // byte offsets, word field shifted by two
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        case (inst[31:26])
            6'b010110: category = cat_cond;     // beq
            6'b010111: category = cat_cond;     // bne
            6'b010100: category = cat_direct;   // b
            6'b010101: category = cat_direct;   // bl
            6'b010011: category = cat_indirect; // jirl
            default:   category = cat_plain;
        endcase
    end

    always_comb begin
        case (category)
            cat_direct:   pc_offset = offs26;
            cat_cond:     pc_offset = offs16;
            cat_indirect: pc_offset = offs16; // relative to rj, not pc
            default:      pc_offset = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: tb.f
decode_pkg.sv
pre_decoder.sv
fetch_buffer.sv
inst_decoder.sv
id_stage.sv
decode_top.sv
tb_decode.sv

// File: tb_decode.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decode import decode_pkg::*; ();

    localparam int BANK_DEPTH = 8;

    // test words with known fields
    localparam logic [31:0] W_ADD      = 32'h0010_0823; // add.w r3, r1, r2
    localparam logic [31:0] W_SUB      = 32'h0011_18a4; // sub.w r4, r5, r6
    localparam logic [31:0] W_ADDI     = 32'h02bf_fd07; // addi.w r7, r8, -1
    localparam logic [31:0] W_LU12I    = 32'h1424_68a9; // lu12i.w r9, 0x12345
    localparam logic [31:0] W_LD       = 32'h2880_216a; // ld.w r10, r11, 8
    localparam logic [31:0] W_ST       = 32'h29bf_f1ac; // st.w r12, r13, -4
    localparam logic [31:0] W_BEQ      = 32'h5800_1022; // beq r1, r2, +16
    localparam logic [31:0] W_BEQ_BACK = 32'h5bff_f822; // beq r1, r2, -8
    localparam logic [31:0] W_BNE      = 32'h5c00_0864; // bne r3, r4, +8
    localparam logic [31:0] W_B        = 32'h5000_2000; // b +32
    localparam logic [31:0] W_BL       = 32'h5400_4000; // bl +64
    localparam logic [31:0] W_JIRL     = 32'h4c00_10a1; // jirl r1, r5, 16
    localparam logic [31:0] W_SYSCALL  = 32'h002b_0005;
    localparam logic [31:0] W_BREAK    = 32'h002a_0003;
    localparam logic [31:0] W_ERTN     = 32'h0648_3800;
    localparam logic [31:0] W_ILL      = 32'hffff_ffff;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
    } dec_exp_t;

    typedef struct packed {
        fetch_pair_t f;
        logic [1:0]  plv;
        logic [1:0]  read_en;
        logic        flush;
        logic        redir;  // redirect expected
        logic        redir0; // raised by slot 0
        logic [31:0] target;
        dec_exp_t    d0;
        dec_exp_t    d1;
    } row_t;

    typedef struct packed {
        dec_exp_t         d;
        logic [31:0]      pc;
        logic [31:0]      pc_next;
        logic [exc_w-1:0] exc;
        logic [31:0]      badv;
        logic             unknown;
    } ref_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        flush;
    logic [1:0]  plv;
    logic [1:0]  read_en;
    fetch_pair_t fetch;
    logic        full;
    uop_t        uop0;
    uop_t        uop1;
    redirect_t   redirect;
    predict_fb_t feedback;

    row_t rows[$];
    ref_t refq[$]; // model of the buffer contents in age order
    row_t r;
    int   errors = 0;
    int   cycles = 0;

    decode_top #(.BANK_DEPTH(BANK_DEPTH)) DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .plv      (plv),
        .read_en  (read_en),
        .fetch    (fetch),
        .full     (full),
        .uop0     (uop0),
        .uop1     (uop1),
        .redirect (redirect),
        .feedback (feedback)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (arst_n) begin
            cycles <= cycles + 1;
            if (cycles > rows.size() + 50) begin
                $display("timeout: table not finished after %0d cycles", cycles);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    function automatic dec_exp_t expect_of(input logic [31:0] w);
        dec_exp_t e;
        e    = '0;
        e.op = op_invalid; // W_ILL and anything unlisted
        case (w)
            W_ADD:      e = '{op_add,     5'd3,  5'd1,  5'd2, 32'h0000_0000};
            W_SUB:      e = '{op_sub,     5'd4,  5'd5,  5'd6, 32'h0000_0000};
            W_ADDI:     e = '{op_addi,    5'd7,  5'd8,  5'd0, 32'hffff_ffff};
            W_LU12I:    e = '{op_lu12i,   5'd9,  5'd0,  5'd0, 32'h1234_5000};
            W_LD:       e = '{op_ld,      5'd10, 5'd11, 5'd0, 32'h0000_0008};
            W_ST:       e = '{op_st,      5'd12, 5'd13, 5'd0, 32'hffff_fffc};
            W_BEQ:      e = '{op_beq,     5'd2,  5'd1,  5'd0, 32'h0000_0010};
            W_BEQ_BACK: e = '{op_beq,     5'd2,  5'd1,  5'd0, 32'hffff_fff8};
            W_BNE:      e = '{op_bne,     5'd4,  5'd3,  5'd0, 32'h0000_0008};
            W_B:        e = '{op_b,       5'd0,  5'd0,  5'd0, 32'h0000_0020};
            W_BL:       e = '{op_bl,      5'd1,  5'd0,  5'd0, 32'h0000_0040};
            W_JIRL:     e = '{op_jirl,    5'd1,  5'd5,  5'd0, 32'h0000_0010};
            W_SYSCALL:  e = '{op_syscall, 5'd0,  5'd0,  5'd0, 32'h0000_0005};
            W_BREAK:    e = '{op_break,   5'd0,  5'd0,  5'd0, 32'h0000_0003};
            W_ERTN:     e = '{op_ertn,    5'd0,  5'd0,  5'd0, 32'h0000_0000};
            INST_NOP:   e = '{op_addi,    5'd0,  5'd0,  5'd0, 32'h0000_0000};
            default:    ;
        endcase
        return e;
    endfunction

    function automatic logic [exc_w-1:0] exc_of(input op_e op, input logic [exc_w-1:0] fexc,
                                                input logic [1:0] lvl);
        if (fexc != '0) return fexc; // fetch fault first
        case (op)
            op_invalid: return EXC_INE;
            op_syscall: return EXC_SYS;
            op_break:   return EXC_BRK;
            op_ertn:    return (lvl != 2'd0) ? EXC_IPE : '0;
            default:    return '0;
        endcase
    endfunction

    function automatic category_e cat_of(input op_e op);
        case (op)
            op_beq, op_bne: return cat_cond;
            op_b, op_bl:    return cat_direct;
            op_jirl:        return cat_indirect;
            default:        return cat_plain;
        endcase
    endfunction

    // predecoded target of one slot
    function automatic logic [31:0] target_of(input logic [31:0] pc, input dec_exp_t d);
        if (cat_of(d.op) == cat_plain) return pc; // no offset field
        return pc + d.imm;
    endfunction

    function automatic logic [31:0] record_of(input logic [31:0] pc, input dec_exp_t d);
        logic [31:0] t;
        t = target_of(pc, d);
        return {t[31:2], cat_of(d.op)};
    endfunction

    function automatic row_t new_row(input logic [31:0] pc, input logic [31:0] i0,
                                     input logic [31:0] i1, input logic [1:0] rd);
        row_t n;
        n           = '0;
        n.f.valid   = 1'b1;
        n.f.inst0   = i0;
        n.f.inst1   = i1;
        n.f.pc      = pc;
        n.f.pc_next = pc[2] ? pc + 32'd4 : pc + 32'd8; // end of the fetch group
        n.read_en   = rd;
        n.d0        = expect_of(i0);
        n.d1        = expect_of(i1);
        return n;
    endfunction

    function automatic row_t idle_row(input logic [1:0] rd);
        row_t n;
        n         = '0;
        n.read_en = rd;
        return n;
    endfunction

    function automatic row_t with_redirect(input row_t n, input logic from0,
                                           input logic [31:0] tgt);
        n.redir  = 1'b1;
        n.redir0 = from0;
        n.target = tgt;
        return n;
    endfunction

    task automatic build_table();
        rows.push_back(new_row(32'h1000, W_ADD, W_SUB, 2'b00));
        rows.push_back(new_row(32'h1008, W_ADDI, W_LU12I, 2'b01));
        rows.push_back(new_row(32'h1010, W_LD, W_ST, 2'b11));
        rows.push_back(new_row(32'h1018, W_BEQ, W_BNE, 2'b11));
        rows.push_back(new_row(32'h1020, W_JIRL, W_ILL, 2'b11));
        rows.push_back(new_row(32'h1028, W_SYSCALL, W_BREAK, 2'b11));
        rows.push_back(new_row(32'h1030, W_ERTN, W_ADD, 2'b11));
        rows.push_back(idle_row(2'b01));
        r     = idle_row(2'b11);
        r.plv = 2'd3; // ertn seen from user level
        rows.push_back(r);
        r        = new_row(32'h1038, W_SYSCALL, INST_NOP, 2'b00);
        r.f.exc  = 7'h40;
        r.f.badv = 32'h0000_1038; // faulting fetch address
        rows.push_back(r);
        rows.push_back(idle_row(2'b11));
        // nop and slot drops
        rows.push_back(new_row(32'h1100, INST_NOP, W_ADD, 2'b00));
        rows.push_back(new_row(32'h110c, W_ADD, W_SUB, 2'b01));
        r                  = new_row(32'h1110, W_B, W_LD, 2'b01);
        r.f.first_inst_jmp = 1'b1;
        r.f.pc_next        = 32'h1130;
        r.f.pred_record0   = 32'h1132; // known and matching
        rows.push_back(r);
        r                  = new_row(32'h1130, W_BL, W_ADD, 2'b11);
        r.f.first_inst_jmp = 1'b1;
        r.f.pc_next        = 32'h1170;
        r.f.pred_record0   = 32'h1172;
        rows.push_back(r);
        rows.push_back(idle_row(2'b01));
        // static redirects
        r            = new_row(32'h1200, W_B, W_ADD, 2'b00);
        r.f.unknown0 = 1'b1;
        rows.push_back(with_redirect(r, 1'b1, 32'h1220));
        r = new_row(32'h1220, W_ADD, W_BEQ_BACK, 2'b01);
        rows.push_back(with_redirect(r, 1'b0, 32'h121c));
        r                  = new_row(32'h1230, W_B, W_ADD, 2'b11);
        r.f.first_inst_jmp = 1'b1;
        r.f.pc_next        = 32'h1300;
        r.f.pred_record0   = 32'h1302; // stale target in the record
        rows.push_back(with_redirect(r, 1'b1, 32'h1250));
        rows.push_back(idle_row(2'b01));
        // fill past the early full and drain
        for (int i = 0; i < 6; i++) begin
            rows.push_back(new_row(32'h2000 + 8 * i, W_ADD, W_SUB, 2'b00));
        end
        for (int i = 0; i < 7; i++) begin
            rows.push_back(idle_row(2'b11));
        end
        rows.push_back(new_row(32'h3000, W_ADD, W_SUB, 2'b00));
        r       = new_row(32'h3008, W_ADDI, W_LD, 2'b00);
        r.flush = 1'b1;
        rows.push_back(r);
        rows.push_back(idle_row(2'b00));
    endtask

    task automatic drive_row(input row_t n);
        fetch   = n.f;
        plv     = n.plv;
        read_en = n.read_en;
        flush   = n.flush;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_uop(input string name, input uop_t u, input int idx,
                             input logic [1:0] lvl);
        ref_t e;
        if (idx >= refq.size()) begin
            expect_eq({name, ".valid"}, 32'(u.valid), 32'd0); // nothing behind
        end else begin
            e = refq[idx];
            expect_eq({name, ".valid"}, 32'(u.valid), 32'd1);
            expect_eq({name, ".op"}, 32'(u.op), 32'(e.d.op));
            expect_eq({name, ".rd"}, 32'(u.rd), 32'(e.d.rd));
            expect_eq({name, ".rj"}, 32'(u.rj), 32'(e.d.rj));
            expect_eq({name, ".rk"}, 32'(u.rk), 32'(e.d.rk));
            expect_eq({name, ".imm"}, u.imm, e.d.imm);
            expect_eq({name, ".pc"}, u.pc, e.pc);
            expect_eq({name, ".pc_next"}, u.pc_next, e.pc_next);
            expect_eq({name, ".exc"}, 32'(u.exc), 32'(exc_of(e.d.op, e.exc, lvl)));
            expect_eq({name, ".badv"}, u.badv, e.badv);
            expect_eq({name, ".unknown"}, 32'(u.unknown), 32'(e.unknown));
        end
    endtask

    task automatic check_row(input row_t n);
        logic [31:0] pc1;
        pc1 = {n.f.pc[31:3], 3'b100};
        expect_eq("redirect.valid", 32'(redirect.valid), 32'(n.redir));
        if (n.redir) expect_eq("redirect.target", redirect.target, n.target);
        expect_eq("feedback.valid", 32'(feedback.valid), 32'(n.f.valid));
        if (n.f.valid) begin
            expect_eq("feedback.pc", feedback.pc, n.f.pc);
            expect_eq("feedback.category0", 32'(feedback.category0), 32'(cat_of(n.d0.op)));
            expect_eq("feedback.category1", 32'(feedback.category1), 32'(cat_of(n.d1.op)));
            if (cat_of(n.d0.op) != cat_plain) begin
                expect_eq("feedback.jmpdist0", feedback.jmpdist0, target_of(n.f.pc, n.d0));
            end
            if (cat_of(n.d1.op) != cat_plain) begin
                expect_eq("feedback.jmpdist1", feedback.jmpdist1, target_of(pc1, n.d1));
            end
        end
        // the fuller bank holds half the entries rounded up
        expect_eq("full", 32'(full), 32'(((refq.size() + 1) / 2) >= BANK_DEPTH - 3));
        check_uop("uop0", uop0, 0, n.plv);
        check_uop("uop1", uop1, 1, n.plv);
    endtask

    task automatic update_ref(input row_t n);
        int          pops;
        logic        s0;
        logic        s1;
        logic [31:0] pc1;
        ref_t        e;
        pc1 = {n.f.pc[31:3], 3'b100}; // second word of the group
        if (n.flush) begin
            refq.delete();
        end else begin
            pops = n.read_en[1] ? 2 : (n.read_en[0] ? 1 : 0);
            while (pops > 0 && refq.size() > 0) begin
                refq.delete(0);
                pops--;
            end
            s0 = n.f.valid && !n.f.pc[2] && (n.f.inst0 != INST_NOP || n.f.exc != '0);
            s1 = n.f.valid && !n.f.first_inst_jmp && !n.redir0
                 && (n.f.inst1 != INST_NOP || n.f.exc != '0);
            if (s0) begin
                e.d       = n.d0;
                e.pc      = n.f.pc;
                e.pc_next = n.redir0 ? n.target
                          : (n.f.first_inst_jmp ? n.f.pc_next : n.f.pc + 32'd4);
                e.exc     = n.f.exc;
                e.badv    = n.f.badv;
                e.unknown = n.f.unknown0 || (n.f.pred_record0 != record_of(n.f.pc, n.d0));
                refq.push_back(e);
            end
            if (s1) begin
                e.d       = n.d1;
                e.pc      = pc1;
                e.pc_next = n.redir ? n.target : n.f.pc_next;
                e.exc     = n.f.exc;
                e.badv    = n.f.badv;
                e.unknown = n.f.unknown1 || (n.f.pred_record1 != record_of(pc1, n.d1));
                refq.push_back(e);
            end
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        flush   = 1'b0;
        plv     = 2'd0;
        read_en = 2'b00;
        fetch   = '0;
        build_table();
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            #30; // well clear of both edges
            check_row(rows[i]);
            update_ref(rows[i]);
            @(posedge clk);
            #2;
        end
        $display("rows applied: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
